// File: list.f
design/core_pkg.sv
design/instr_decode.sv
design/arch_reg_file.sv
design/execute_unit.sv
design/reorder_buffer.sv
design/ooo_core.sv
testbench/ooo_core_assert.sv
testbench/ooo_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ooo_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ooo_core_tb -f list.f \
    --Mdir obj_dir -o ooo_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/ooo_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1

// File: testbench/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb;

    localparam int N_ENTRIES   = 26;
    localparam int N_TESTS     = 6;
    localparam int EXP_COMMITS = 22;

    logic        clk;
    logic        rst_n;
    logic        instr_req;
    logic [31:0] instr;
    logic [31:0] instr_pc;
    logic        instr_ack;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;
    logic        store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic        flush;
    logic [31:0] redirect_pc;

    // program table, indexed by pc/4
    logic [31:0] tbl_word   [N_ENTRIES];
    logic [4:0]  exp_rd     [N_ENTRIES];
    logic [31:0] exp_data   [N_ENTRIES];
    logic        exp_store  [N_ENTRIES];
    logic [31:0] exp_addr   [N_ENTRIES];
    logic        exp_taken  [N_ENTRIES];
    logic [31:0] exp_target [N_ENTRIES];
    int          test_of    [N_ENTRIES];
    int          test_last  [N_TESTS];
    string       test_name  [N_TESTS];

    int          errors;
    int          commits;
    int          test_err_base;
    int          seed;
    int          drv_idx;
    int          gap;
    logic [31:0] next_pc;
    logic        flush_due;
    logic [31:0] flush_target;
    logic        redirect_seen;
    logic [31:0] redirect_addr;
    logic        all_done;

    // small rob and slow mul so the rob fills behind a mul
    ooo_core #(
        .ROB_DEPTH   (4),
        .MUL_LATENCY (40)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_req    (instr_req),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .instr_ack    (instr_ack),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_data   (store_data),
        .flush        (flush),
        .redirect_pc  (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_br(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic add_entry(input int idx, input logic [31:0] word, input logic [4:0] rd,
                             input logic [31:0] data, input logic st, input logic [31:0] addr,
                             input logic tk, input logic [31:0] target, input int test);
        tbl_word[idx]   = word;
        exp_rd[idx]     = rd;
        exp_data[idx]   = data;
        exp_store[idx]  = st;
        exp_addr[idx]   = addr;
        exp_taken[idx]  = tk;
        exp_target[idx] = target;
        test_of[idx]    = test;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    initial begin
        // values worked out by hand under in-order semantics
        add_entry(0,  enc_addi(12'd5, 5'd0, 5'd1),                5'd1, 32'd5, 0, 0, 0, 0, 0);
        add_entry(1,  enc_addi(12'hffd, 5'd0, 5'd2),      5'd2, 32'hfffffffd, 0, 0, 0, 0, 0);
        add_entry(2,  enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3),     5'd3, 32'd2, 0, 0, 0, 0, 0);
        add_entry(3,  enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4),     5'd4, 32'd8, 0, 0, 0, 0, 0);
        add_entry(4,  enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5),     5'd5, 32'd5, 0, 0, 0, 0, 0);
        add_entry(5,  enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 5'd6, 32'hfffffffd, 0, 0, 0, 0, 0);
        add_entry(6,  enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 5'd7, 32'hfffffff8, 0, 0, 0, 0, 0);
        add_entry(7,  enc_addi(12'd7, 5'd1, 5'd0),                5'd0, 32'd0, 0, 0, 0, 0, 0);
        // x0 must still read zero
        add_entry(8,  enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd8),     5'd8, 32'd0, 0, 0, 0, 0, 0);
        add_entry(9,  enc_r(7'h01, 5'd4, 5'd1, 3'b000, 5'd9),     5'd9, 32'd40, 0, 0, 0, 0, 1);
        add_entry(10, enc_addi(12'd11, 5'd0, 5'd10),             5'd10, 32'd11, 0, 0, 0, 0, 1);
        add_entry(11, enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd11),   5'd11, 32'd10, 0, 0, 0, 0, 1);
        add_entry(12, enc_r(7'h00, 5'd1, 5'd9, 3'b000, 5'd12),   5'd12, 32'd45, 0, 0, 0, 0, 2);
        add_entry(13, enc_sw(12'd16, 5'd12, 5'd1),                5'd0, 32'd45, 1, 21, 0, 0, 3);
        add_entry(14, enc_br(13'd8, 5'd2, 5'd1, 3'b000),          5'd0, 32'd0, 0, 0, 0, 0, 4);
        add_entry(15, enc_br(13'd12, 5'd2, 5'd1, 3'b001),         5'd0, 32'd0, 0, 0, 1, 72, 4);
        // wrong path, never committed
        add_entry(16, enc_addi(12'd99, 5'd0, 5'd13),             5'd13, 32'd99, 0, 0, 0, 0, 4);
        add_entry(17, enc_addi(12'd77, 5'd0, 5'd14),             5'd14, 32'd77, 0, 0, 0, 0, 4);
        add_entry(18, enc_r(7'h01, 5'd11, 5'd10, 3'b000, 5'd15), 5'd15, 32'd110, 0, 0, 0, 0, 5);
        add_entry(19, enc_addi(12'd1, 5'd0, 5'd16),              5'd16, 32'd1, 0, 0, 0, 0, 5);
        add_entry(20, enc_addi(12'd2, 5'd0, 5'd17),              5'd17, 32'd2, 0, 0, 0, 0, 5);
        add_entry(21, enc_br(13'd12, 5'd1, 5'd1, 3'b000),        5'd0, 32'd0, 0, 0, 1, 96, 5);
        // waits on the full rob, then issues down the wrong path
        add_entry(22, enc_addi(12'd3, 5'd0, 5'd18),              5'd18, 32'd3, 0, 0, 0, 0, 5);
        add_entry(23, enc_addi(12'd55, 5'd0, 5'd19),             5'd19, 32'd55, 0, 0, 0, 0, 5);
        add_entry(24, enc_addi(12'hff6, 5'd15, 5'd20),           5'd20, 32'd100, 0, 0, 0, 0, 5);
        add_entry(25, enc_sw(12'd0, 5'd20, 5'd0),                 5'd0, 32'd100, 1, 0, 0, 0, 5);
        test_name[0] = "alu and addi";
        test_name[1] = "mul with younger adds";
        test_name[2] = "true dependency";
        test_name[3] = "store";
        test_name[4] = "branches";
        test_name[5] = "back-to-back behind mul";
        test_last[0] = 8;
        test_last[1] = 11;
        test_last[2] = 12;
        test_last[3] = 13;
        test_last[4] = 15;
        test_last[5] = 25;
    end

    // commit monitor, samples mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (flush && !flush_due) begin
                $display("flush raised at %0d ns without a taken branch commit", $time);
                errors++;
            end else if (flush_due && !flush) begin
                $display("flush missing at %0d ns after a taken branch commit", $time);
                errors++;
            end else if (flush) begin
                check_val("redirect_pc", redirect_pc, flush_target);
                redirect_addr = redirect_pc;
                redirect_seen = 1'b1;
            end
            flush_due = 1'b0;
            if (commit_valid) begin
                int idx;
                idx = int'(commit_pc >> 2);
                commits++;
                check_val("commit_pc", commit_pc, next_pc);
                if (idx < 0 || idx >= N_ENTRIES) begin
                    $display("commit from pc %h outside the program", commit_pc);
                    errors++;
                end else begin
                    check_val("commit_rd", 32'(commit_rd), 32'(exp_rd[idx]));
                    if (exp_rd[idx] != 5'd0) begin
                        check_val("commit_data", commit_data, exp_data[idx]);
                    end
                    check_val("store_valid", 32'(store_valid), 32'(exp_store[idx]));
                    if (exp_store[idx]) begin
                        check_val("store_addr", store_addr, exp_addr[idx]);
                        check_val("store_data", store_data, exp_data[idx]);
                    end
                    if (exp_taken[idx]) begin
                        flush_due    = 1'b1;
                        flush_target = exp_target[idx];
                        next_pc      = exp_target[idx];
                    end else begin
                        next_pc = commit_pc + 32'd4;
                    end
                    if (idx == test_last[test_of[idx]]) begin
                        $display("test %0d (%s) finished with %0d errors", test_of[idx] + 1,
                                 test_name[test_of[idx]], errors - test_err_base);
                        test_err_base = errors;
                    end
                    if (idx == N_ENTRIES - 1) begin
                        all_done = 1'b1;
                    end
                end
            end
        end
    end

    // four-phase driver
    initial begin
        seed          = 32'hcab830b0;
        errors        = 0;
        commits       = 0;
        test_err_base = 0;
        next_pc       = 32'd0;
        flush_due     = 1'b0;
        flush_target  = 32'd0;
        redirect_seen = 1'b0;
        redirect_addr = 32'd0;
        all_done      = 1'b0;
        drv_idx       = 0;
        rst_n         = 1'b0;
        instr_req     = 1'b0;
        instr         = 32'd0;
        instr_pc      = 32'd0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        while (!all_done) begin
            if (redirect_seen) begin
                redirect_seen = 1'b0;
                drv_idx       = int'(redirect_addr >> 2);
            end
            if (drv_idx < N_ENTRIES) begin
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(posedge clk);
                @(posedge clk);
                if (!redirect_seen) begin
                    instr_req <= 1'b1;
                    instr     <= tbl_word[drv_idx];
                    instr_pc  <= 32'(drv_idx * 4);
                    do begin
                        @(posedge clk);
                    end while (!instr_ack && !redirect_seen);
                    instr_req <= 1'b0;
                    if (!redirect_seen) begin
                        drv_idx++;
                    end
                    do begin
                        @(posedge clk);
                    end while (instr_ack);
                end
            end else begin
                @(posedge clk);
            end
        end
        repeat (4) @(posedge clk);
        check_val("commit count", 32'(commits), 32'(EXP_COMMITS));
        $display("%0d tests, %0d commits, %0d errors", N_TESTS, commits, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(N_ENTRIES * 40 * 8);
        $display("timeout: the program did not finish committing in time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: testbench/ooo_core_assert.sv
`timescale 1ns/1ps

module ooo_core_assert (
    input logic       clk,
    input logic       rst_n,
    input logic       instr_req,
    input logic       instr_ack,
    input logic       flush,
    input logic       commit_valid,
    input logic       store_valid,
    input logic [4:0] commit_rd
);

    // ack only rises on a live request
    ack_rise_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(instr_ack) |-> $past(instr_req))
        else $error("instr_ack rose without instr_req");

    ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(instr_ack) |-> !$past(instr_req))
        else $error("instr_ack fell while instr_req was high");

    flush_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !flush)
        else $error("flush lasted more than one cycle");

    // a store never writes a register
    store_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(store_valid && commit_valid && commit_rd != 5'd0))
        else $error("store commit with a register write");

endmodule

bind ooo_core ooo_core_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_req    (instr_req),
    .instr_ack    (instr_ack),
    .flush        (flush),
    .commit_valid (commit_valid),
    .store_valid  (store_valid),
    .commit_rd    (commit_rd)
);

// File: design/ooo_core.sv
`timescale 1ns/1ps

module ooo_core #(
    parameter int ROB_DEPTH   = 8,
    parameter int MUL_LATENCY = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_req,
    input  logic [31:0] instr,
    input  logic [31:0] instr_pc,
    output logic        instr_ack,
    output logic        commit_valid,
    output logic [31:0] commit_pc,
    output logic [4:0]  commit_rd,
    output logic [31:0] commit_data,
    output logic        store_valid,
    output logic [31:0] store_addr,
    output logic [31:0] store_data,
    output logic        flush,
    output logic [31:0] redirect_pc
);

    localparam int TW = core_pkg::tag_bits(ROB_DEPTH);

    logic           rob_full;
    logic           ex_ready;
    logic [4:0]     raddr_a;
    logic [4:0]     raddr_b;
    logic [31:0]    rdata_a;
    logic [31:0]    rdata_b;
    logic           pend_a;
    logic           pend_b;
    logic           set_pending;
    logic [4:0]     set_rd;

    // issue bus
    logic           issue_valid;
    logic [TW-1:0]  issue_tag;
    core_pkg::uop_e issue_uop;
    logic [31:0]    issue_a;
    logic [31:0]    issue_b;
    logic [31:0]    issue_imm;
    logic [31:0]    issue_pc;
    logic [4:0]     issue_rd;

    // completion bus
    logic           wb_valid;
    logic [TW-1:0]  wb_tag;
    logic [31:0]    wb_value;
    logic           wb_taken;
    logic [31:0]    wb_target;

    instr_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_req   (instr_req),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .rob_full    (rob_full),
        .ex_ready    (ex_ready),
        .pend_a      (pend_a),
        .pend_b      (pend_b),
        .rdata_a     (rdata_a),
        .rdata_b     (rdata_b),
        .flush       (flush),
        .instr_ack   (instr_ack),
        .raddr_a     (raddr_a),
        .raddr_b     (raddr_b),
        .set_pending (set_pending),
        .set_rd      (set_rd),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_imm   (issue_imm),
        .issue_pc    (issue_pc),
        .issue_rd    (issue_rd)
    );

    arch_reg_file u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .raddr_a      (raddr_a),
        .raddr_b      (raddr_b),
        .set_pending  (set_pending),
        .set_rd       (set_rd),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .flush        (flush),
        .rdata_a      (rdata_a),
        .rdata_b      (rdata_b),
        .pend_a       (pend_a),
        .pend_b       (pend_b)
    );

    execute_unit #(
        .ROB_DEPTH   (ROB_DEPTH),
        .MUL_LATENCY (MUL_LATENCY)
    ) u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_tag   (issue_tag),
        .issue_uop   (issue_uop),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_imm   (issue_imm),
        .issue_pc    (issue_pc),
        .flush       (flush),
        .ex_ready    (ex_ready),
        .wb_valid    (wb_valid),
        .wb_tag      (wb_tag),
        .wb_value    (wb_value),
        .wb_taken    (wb_taken),
        .wb_target   (wb_target)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_uop    (issue_uop),
        .issue_pc     (issue_pc),
        .issue_rd     (issue_rd),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag),
        .wb_value     (wb_value),
        .wb_taken     (wb_taken),
        .wb_target    (wb_target),
        .rob_full     (rob_full),
        .issue_tag    (issue_tag),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_data   (store_data),
        .flush        (flush),
        .redirect_pc  (redirect_pc)
    );

endmodule

// File: design/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  issue_valid,
    input  core_pkg::uop_e                        issue_uop,
    input  logic [31:0]                           issue_pc,
    input  logic [4:0]                            issue_rd,
    input  logic                                  wb_valid,
    input  logic [core_pkg::tag_bits(ROB_DEPTH)-1:0] wb_tag,
    input  logic [31:0]                           wb_value,
    input  logic                                  wb_taken,
    input  logic [31:0]                           wb_target,
    output logic                                  rob_full,
    output logic [core_pkg::tag_bits(ROB_DEPTH)-1:0] issue_tag,
    output logic                                  commit_valid,
    output logic [31:0]                           commit_pc,
    output logic [4:0]                            commit_rd,
    output logic [31:0]                           commit_data,
    output logic                                  store_valid,
    output logic [31:0]                           store_addr,
    output logic [31:0]                           store_data,
    output logic                                  flush,
    output logic [31:0]                           redirect_pc
);

    localparam int TW = core_pkg::tag_bits(ROB_DEPTH);

    logic [TW-1:0] head;
    logic [TW-1:0] tail;
    logic [TW-1:0] head_nx;
    logic [TW-1:0] tail_nx;
    logic [TW:0]   count;
    logic          commit_fire;

    // entry store
    logic          e_done   [ROB_DEPTH];
    logic [4:0]    e_rd     [ROB_DEPTH];
    logic [31:0]   e_value  [ROB_DEPTH];
    logic [31:0]   e_pc     [ROB_DEPTH];
    logic          e_store  [ROB_DEPTH];
    logic          e_taken  [ROB_DEPTH];
    logic [31:0]   e_target [ROB_DEPTH];

    // depth need not be a power of two
    assign head_nx = (head == TW'(ROB_DEPTH - 1)) ? '0 : head + 1'b1;
    assign tail_nx = (tail == TW'(ROB_DEPTH - 1)) ? '0 : tail + 1'b1;

    assign rob_full  = (count == (TW + 1)'(ROB_DEPTH));
    assign issue_tag = tail;

    // nothing retires while the flush is out
    assign commit_fire  = (count != '0) && e_done[head] && !flush;
    assign commit_valid = commit_fire;
    assign store_valid  = commit_fire && e_store[head];
    assign commit_pc    = e_pc[head];
    assign commit_rd    = e_rd[head];
    assign commit_data  = e_value[head];
    assign store_addr   = e_target[head];
    assign store_data   = e_value[head];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            flush <= 1'b0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            flush <= 1'b0;
        end else begin
            if (issue_valid) begin
                tail <= tail_nx;
            end
            if (commit_fire) begin
                head <= head_nx;
            end
            count <= count + (TW + 1)'(issue_valid) - (TW + 1)'(commit_fire);
            flush <= commit_fire && e_taken[head];
        end
    end

    always_ff @(posedge clk) begin
        if (commit_fire) begin
            redirect_pc <= e_target[head];
        end
    end

    // allocate at tail, complete by tag
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            e_done[tail]  <= 1'b0;
            e_rd[tail]    <= issue_rd;
            e_pc[tail]    <= issue_pc;
            e_store[tail] <= (issue_uop == core_pkg::UOP_SW);
        end
        if (wb_valid && !flush) begin
            e_done[wb_tag]   <= 1'b1;
            e_value[wb_tag]  <= wb_value;
            e_taken[wb_tag]  <= wb_taken;
            e_target[wb_tag] <= wb_target;
        end
    end

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit #(
    parameter int ROB_DEPTH   = 8,
    parameter int MUL_LATENCY = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  issue_valid,
    input  logic [core_pkg::tag_bits(ROB_DEPTH)-1:0] issue_tag,
    input  core_pkg::uop_e                        issue_uop,
    input  logic [31:0]                           issue_a,
    input  logic [31:0]                           issue_b,
    input  logic [31:0]                           issue_imm,
    input  logic [31:0]                           issue_pc,
    input  logic                                  flush,
    output logic                                  ex_ready,
    output logic                                  wb_valid,
    output logic [core_pkg::tag_bits(ROB_DEPTH)-1:0] wb_tag,
    output logic [31:0]                           wb_value,
    output logic                                  wb_taken,
    output logic [31:0]                           wb_target
);

    localparam int TW  = core_pkg::tag_bits(ROB_DEPTH);
    // multiplier bits retired per step, the last cycle only presents the result
    localparam int BPS = (32 + MUL_LATENCY - 2) / (MUL_LATENCY - 1);
    localparam int CW  = $clog2(MUL_LATENCY + 1);

    logic          issue_alu;
    logic          issue_mul;
    logic          alu_v;
    logic [TW-1:0] alu_tag;
    logic [31:0]   alu_value;
    logic          alu_taken;
    logic [31:0]   alu_target;
    logic [31:0]   n_value;
    logic          n_taken;
    logic [31:0]   n_target;
    logic          mul_busy;
    logic          mul_fin;
    logic [CW-1:0] mul_cnt;
    logic [TW-1:0] mul_tag;
    logic [31:0]   mul_acc;
    logic [31:0]   mul_mcand;
    logic [31:0]   mul_mplier;
    logic [31:0]   mul_step;

    assign issue_mul = issue_valid && (issue_uop == core_pkg::UOP_MUL);
    assign issue_alu = issue_valid && (issue_uop != core_pkg::UOP_MUL);
    assign mul_fin   = mul_busy && (mul_cnt == '0);

    // held alu result or a second mul would be lost
    assign ex_ready = !(alu_v && mul_fin) && !(mul_busy && issue_uop == core_pkg::UOP_MUL);

    always_comb begin
        n_value  = '0;
        n_taken  = 1'b0;
        n_target = issue_pc + issue_imm;
        case (issue_uop)
            core_pkg::UOP_ADD:  n_value = issue_a + issue_b;
            core_pkg::UOP_SUB:  n_value = issue_a - issue_b;
            core_pkg::UOP_AND:  n_value = issue_a & issue_b;
            core_pkg::UOP_OR:   n_value = issue_a | issue_b;
            core_pkg::UOP_XOR:  n_value = issue_a ^ issue_b;
            core_pkg::UOP_ADDI: n_value = issue_a + issue_imm;
            core_pkg::UOP_BEQ:  n_taken = (issue_a == issue_b);
            core_pkg::UOP_BNE:  n_taken = (issue_a != issue_b);
            core_pkg::UOP_SW: begin
                n_value  = issue_b;
                n_target = issue_a + issue_imm;
            end
            default: n_value = '0;
        endcase
    end

    // shift-and-add over the low BPS multiplier bits
    always_comb begin
        mul_step = mul_acc;
        for (int i = 0; i < BPS; i++) begin
            if (mul_mplier[i]) begin
                mul_step = mul_step + (mul_mcand << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            alu_v    <= 1'b0;
            mul_busy <= 1'b0;
        end else begin
            alu_v <= issue_alu || (alu_v && mul_fin);
            if (issue_mul) begin
                mul_busy <= 1'b1;
            end else if (mul_fin) begin
                mul_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_alu) begin
            alu_tag    <= issue_tag;
            alu_value  <= n_value;
            alu_taken  <= n_taken;
            alu_target <= n_target;
        end
        if (issue_mul) begin
            mul_tag    <= issue_tag;
            mul_cnt    <= CW'(MUL_LATENCY - 1);
            mul_acc    <= '0;
            mul_mcand  <= issue_a;
            mul_mplier <= issue_b;
        end else if (mul_busy && mul_cnt != '0) begin
            mul_cnt    <= mul_cnt - 1'b1;
            mul_acc    <= mul_step;
            mul_mcand  <= mul_mcand << BPS;
            mul_mplier <= mul_mplier >> BPS;
        end
    end

    // multiplier wins the port, alu waits in its register
    assign wb_valid  = mul_fin || alu_v;
    assign wb_tag    = mul_fin ? mul_tag : alu_tag;
    assign wb_value  = mul_fin ? mul_acc : alu_value;
    assign wb_taken  = !mul_fin && alu_taken;
    assign wb_target = alu_target;

endmodule

// File: design/arch_reg_file.sv
`timescale 1ns/1ps

module arch_reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  raddr_a,
    input  logic [4:0]  raddr_b,
    input  logic        set_pending,
    input  logic [4:0]  set_rd,
    input  logic        commit_valid,
    input  logic [4:0]  commit_rd,
    input  logic [31:0] commit_data,
    input  logic        flush,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b,
    output logic        pend_a,
    output logic        pend_b
);

    logic [31:0] regs [32];
    // in-flight writers per register, so a second writer keeps the register busy
    logic [3:0]  pend_cnt [32];

    assign rdata_a = (raddr_a == 5'd0) ? 32'd0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? 32'd0 : regs[raddr_b];
    assign pend_a  = (pend_cnt[raddr_a] != 4'd0);
    assign pend_b  = (pend_cnt[raddr_b] != 4'd0);

    always_ff @(posedge clk) begin
        if (commit_valid && commit_rd != 5'd0) begin
            regs[commit_rd] <= commit_data;
        end
    end

    // set and clear of the same register in one cycle leaves it pending
    always_ff @(posedge clk) begin
        for (int r = 0; r < 32; r++) begin
            if (!rst_n || flush) begin
                pend_cnt[r] <= 4'd0;
            end else if (set_pending && set_rd == 5'(r)) begin
                if (!(commit_valid && commit_rd == 5'(r))) begin
                    pend_cnt[r] <= pend_cnt[r] + 4'd1;
                end
            end else if (commit_valid && commit_rd == 5'(r) && r != 0) begin
                pend_cnt[r] <= pend_cnt[r] - 4'd1;
            end
        end
    end

endmodule

// File: design/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_req,
    input  logic [31:0]        instr,
    input  logic [31:0]        instr_pc,
    input  logic               rob_full,
    input  logic               ex_ready,
    input  logic               pend_a,
    input  logic               pend_b,
    input  logic [31:0]        rdata_a,
    input  logic [31:0]        rdata_b,
    input  logic               flush,
    output logic               instr_ack,
    output logic [4:0]         raddr_a,
    output logic [4:0]         raddr_b,
    output logic               set_pending,
    output logic [4:0]         set_rd,
    output logic               issue_valid,
    output core_pkg::uop_e     issue_uop,
    output logic [31:0]        issue_a,
    output logic [31:0]        issue_b,
    output logic [31:0]        issue_imm,
    output logic [31:0]        issue_pc,
    output logic [4:0]         issue_rd
);

    core_pkg::instr_u iw;
    logic [6:0]       opc;
    logic [9:0]       fn;
    logic             legal;
    logic             uses_a;
    logic             uses_b;
    logic             writes_rd;
    logic             hazard;

    assign iw  = instr;
    assign opc = iw.r_view.opcode;
    assign fn  = {iw.r_view.funct7, iw.r_view.funct3};

    always_comb begin
        issue_uop = core_pkg::UOP_ADDI;
        legal     = 1'b1;
        uses_a    = 1'b1;
        uses_b    = 1'b0;
        writes_rd = 1'b0;
        issue_imm = {{20{iw.i_view.imm12[11]}}, iw.i_view.imm12};
        case (opc)
            core_pkg::OPC_OP: begin
                uses_b    = 1'b1;
                writes_rd = 1'b1;
                case (fn)
                    10'b0000000_000: issue_uop = core_pkg::UOP_ADD;
                    10'b0100000_000: issue_uop = core_pkg::UOP_SUB;
                    10'b0000000_111: issue_uop = core_pkg::UOP_AND;
                    10'b0000000_110: issue_uop = core_pkg::UOP_OR;
                    10'b0000000_100: issue_uop = core_pkg::UOP_XOR;
                    10'b0000001_000: issue_uop = core_pkg::UOP_MUL;
                    default:         legal = 1'b0;
                endcase
            end
            core_pkg::OPC_OPIMM: begin
                writes_rd = 1'b1;
                legal     = (iw.i_view.funct3 == 3'b000);
            end
            core_pkg::OPC_BRANCH: begin
                uses_b    = 1'b1;
                // b immediate is scattered over funct7 and rd
                issue_imm = {{20{iw.r_view.funct7[6]}}, iw.r_view.rd[0],
                             iw.r_view.funct7[5:0], iw.r_view.rd[4:1], 1'b0};
                case (iw.r_view.funct3)
                    3'b000:  issue_uop = core_pkg::UOP_BEQ;
                    3'b001:  issue_uop = core_pkg::UOP_BNE;
                    default: legal = 1'b0;
                endcase
            end
            core_pkg::OPC_STORE: begin
                uses_b    = 1'b1;
                issue_uop = core_pkg::UOP_SW;
                issue_imm = {{20{iw.r_view.funct7[6]}}, iw.r_view.funct7, iw.r_view.rd};
                legal     = (iw.r_view.funct3 == 3'b010);
            end
            default: legal = 1'b0;
        endcase
        // anything else becomes addi x0, nop
        if (!legal) begin
            issue_uop = core_pkg::UOP_ADDI;
            uses_a    = 1'b0;
            uses_b    = 1'b0;
            writes_rd = 1'b0;
            issue_imm = '0;
        end
    end

    assign raddr_a  = iw.r_view.rs1;
    assign raddr_b  = iw.r_view.rs2;
    assign issue_a  = rdata_a;
    assign issue_b  = rdata_b;
    assign issue_pc = instr_pc;
    assign issue_rd = writes_rd ? iw.r_view.rd : 5'd0;

    // no forwarding, wait for the producer to commit
    assign hazard      = (uses_a && pend_a) || (uses_b && pend_b);
    assign issue_valid = instr_req && !instr_ack && !rob_full && ex_ready && !hazard && !flush;

    assign set_pending = issue_valid && (issue_rd != 5'd0);
    assign set_rd      = issue_rd;

    // four-phase ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_ack <= 1'b0;
        end else if (issue_valid) begin
            instr_ack <= 1'b1;
        end else if (!instr_req) begin
            instr_ack <= 1'b0;
        end
    end

endmodule

// File: design/core_pkg.sv
package core_pkg;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef enum logic [3:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_MUL,
        UOP_ADDI,
        UOP_BEQ,
        UOP_BNE,
        UOP_SW
    } uop_e;

    // register format, also the source of the S and B immediates
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
    } instr_u;

    // width of a rob tag for a given depth
    function automatic int tag_bits(input int depth);
        return (depth > 1) ? $clog2(depth) : 1;
    endfunction

endpackage
